//--- tb.f
hdl/csa_pkg.sv
hdl/csa_ram.sv
hdl/csa_seed_unpack.sv
hdl/stream_cypher.sv
hdl/csa_iterate.sv
hdl/csa_key_core.sv
tb/csa_key_core_props.sv
tb/tb_csa_key_core.sv

//--- tb/tb_csa_key_core.sv
module tb_csa_key_core;

	logic                          S_AXI_ACLK = 1'b0;
	logic                          rst;
	logic                          wen;
	logic [csa_pkg::ADDR_W-1:0]    waddr;
	logic [csa_pkg::DATA_W-1:0]    wdata;
	logic                          ren;
	logic [csa_pkg::ADDR_W-1:0]    raddr;
	logic [csa_pkg::DATA_W-1:0]    rdata;
	logic [csa_pkg::RESULT_W-1:0]  byte_ram_out;
	logic                          ready;

	string       test_name [5];
	int          test_nwords [5];
	int          test_items [5]; // Whole items, words*4/5.
	logic [31:0] test_words [5][20];

	logic [47:0] got_q [$];
	int          got_cyc_q [$];
	int          cyc = 0;
	int          cycle_limit = 0;
	int          errors = 0;
	int          checks = 0;

	csa_key_core u_csa_key_core (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.rst          (rst),
		.wen          (wen),
		.waddr        (waddr),
		.S_AXI_WDATA  (wdata),
		.ren          (ren),
		.raddr        (raddr),
		.rdata        (rdata),
		.byte_ram_out (byte_ram_out),
		.ready        (ready)
	);

	always #5 S_AXI_ACLK = ~S_AXI_ACLK;

	always @(posedge S_AXI_ACLK) begin
		cyc = cyc + 1;
		if (cyc > cycle_limit) begin
			$display("timeout at cycle %0d, the run did not complete", cyc);
			$display("TEST FAIL");
			$finish;
		end
	end

	// Results are taken mid-cycle.
	always @(negedge S_AXI_ACLK) begin
		if (ready) begin
			got_q.push_back(byte_ram_out);
			got_cyc_q.push_back(cyc);
		end
	end

	task automatic fill_table();
		test_name[0] = "fixed_5w";
		test_name[1] = "random_20w";
		test_name[2] = "restart_7w";
		test_name[3] = "empty_0w";
		test_name[4] = "empty_1w";
		test_nwords = '{5, 20, 7, 0, 1};
		test_items = '{4, 16, 5, 0, 0};
		for (int i = 0; i < 20; i++) begin
			test_words[0][i] = {8'(4 * i + 3), 8'(4 * i + 2), 8'(4 * i + 1), 8'(4 * i)};
			test_words[1][i] = $urandom();
			test_words[2][i] = $urandom();
			test_words[3][i] = '0;
			test_words[4][i] = $urandom();
		end
	endtask

	function automatic int run_length();
		int len;
		len = 10;
		for (int t = 0; t < 5; t++)
			len += 2 + test_nwords[t] + 16 + (3 + csa_pkg::MAX_CAL_TIMES)
				+ test_items[t] * (3 + csa_pkg::MAX_CAL_TIMES) + 2 * csa_pkg::MAX_CAL_TIMES;
		return len + 100;
	endfunction

	// Byte k of an item, little-endian in the word store.
	function automatic logic [7:0] item_byte(input int t, input int item, input int k);
		int a;
		a = 5 * item + k;
		return test_words[t][a / 4][(a % 4) * 8 +: 8];
	endfunction

	function automatic logic [47:0] model_result(input int t, input int item);
		logic [63:0] sb;
		logic [7:0]  b [5];
		logic [7:0]  c [8];
		logic [7:0]  cb [8];
		logic [7:0]  p [8];
		logic [7:0]  mask [8];
		logic [7:0]  nb;
		logic [47:0] res;
		sb = 64'hE613DB6DC11C4524;
		mask = '{8'hB5, 8'h93, 8'h5E, 8'hD6, 8'hB0, 8'hD7, 8'hD7, 8'h00};
		res = '0;
		for (int k = 0; k < 5; k++)
			b[k] = item_byte(t, item, k);
		c = '{b[0], b[1], b[2], b[0] + b[1] + b[2], b[3], b[4], 8'h00, b[3] + b[4]};
		for (int n = 0; n < csa_pkg::MAX_CAL_TIMES; n++) begin
			for (int i = 0; i < 8; i++) begin
				nb = c[(i + 1) % 8];
				cb[i] = sb[i * 8 +: 8] ^ c[i] ^ {nb[6:0], nb[7]};
			end
			if (n == csa_pkg::MAX_CAL_TIMES - 1) begin
				for (int i = 0; i < 6; i++)
					res[i * 8 +: 8] = cb[i] ^ mask[i];
			end else begin
				for (int j = 0; j < 8; j++)
					p[j] = (cb[j] ^ mask[j]) + 8'(n);
				c = '{p[0], p[1], p[2], p[0] + p[1] + p[2], p[4], p[5], p[6], p[4] + p[5] + p[6]};
			end
		end
		return res;
	endfunction

	task automatic write_step(input logic [3:0] addr, input logic [31:0] data);
		wen = 1'b1;
		waddr = addr;
		wdata = data;
		@(posedge S_AXI_ACLK);
		#1;
		wen = 1'b0;
	endtask

	task automatic read_check(input int t, input logic [3:0] addr, input logic [31:0] exp);
		ren = 1'b1;
		raddr = addr;
		@(posedge S_AXI_ACLK);
		#1;
		ren = 1'b0;
		checks++;
		assert (rdata === exp)
		else begin
			$display("error: %s read addr %0d expected %h actual %h",
				test_name[t], addr, exp, rdata);
			errors++;
		end
	endtask

	task automatic run_test(input int t);
		int          fin_cyc;
		int          n_err;
		int          gap;
		int          exp_gap;
		logic [47:0] exp;
		n_err = errors;
		write_step(csa_pkg::STEP_REQ_STUFF, '0);
		for (int i = 0; i < test_nwords[t]; i++)
			write_step(csa_pkg::STEP_STUFFING_DATA, test_words[t][i]);
		for (int a = 0; a < 16; a++) begin
			if (a < test_nwords[t])
				read_check(t, 4'(a), test_words[t][a]);
			else
				read_check(t, 4'(a), {16'hE000, 12'h000, 4'(a)});
		end
		got_q.delete();
		got_cyc_q.delete();
		write_step(csa_pkg::STEP_FIN_STUFF, '0);
		fin_cyc = cyc; // Edge that took the finish step.
		while (got_q.size() < test_items[t]) begin
			@(posedge S_AXI_ACLK);
			#1;
		end
		repeat (2 * csa_pkg::MAX_CAL_TIMES) @(posedge S_AXI_ACLK);
		#1;
		checks++;
		assert (got_q.size() == test_items[t])
		else begin
			$display("error: %s ready count expected %0d actual %0d",
				test_name[t], test_items[t], got_q.size());
			errors++;
		end
		for (int k = 0; k < got_q.size() && k < test_items[t]; k++) begin
			exp = model_result(t, k);
			checks++;
			assert (got_q[k] === exp)
			else begin
				$display("error: %s item %0d expected %h actual %h", test_name[t], k, exp, got_q[k]);
				errors++;
			end
			gap = (k == 0) ? got_cyc_q[0] + 1 - fin_cyc : got_cyc_q[k] - got_cyc_q[k - 1];
			exp_gap = (k == 0) ? 2 + csa_pkg::MAX_CAL_TIMES + 1 : 3 + csa_pkg::MAX_CAL_TIMES;
			checks++;
			assert (gap == exp_gap)
			else begin
				$display("error: %s item %0d cycles expected %0d actual %0d",
					test_name[t], k, exp_gap, gap);
				errors++;
			end
		end
		$display("%s: %0d results, %0d mismatches", test_name[t], got_q.size(), errors - n_err);
	endtask

	initial begin
		void'($urandom(22));
		rst = 1'b1;
		wen = 1'b0;
		waddr = '0;
		wdata = '0;
		ren = 1'b0;
		raddr = '0;
		fill_table();
		cycle_limit = run_length();
		repeat (10) @(posedge S_AXI_ACLK);
		#1;
		rst = 1'b0;
		for (int t = 0; t < 5; t++)
			run_test(t);
		$display("tests %0d, checks %0d, failed checks %0d", 5, checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

//--- tb/csa_key_core_props.sv
module csa_key_core_props (
	input logic                S_AXI_ACLK,
	input logic                rst,
	input logic                ready,
	input logic                seed_valid,
	input csa_pkg::eng_state_e state
);

	// Ready is a one-cycle pulse.
	a_ready_pulse: assert property (@(posedge S_AXI_ACLK) disable iff (rst)
		ready |=> !ready)
		else $error("ready stayed high for two cycles in a row");

	a_ready_after_reset: assert property (@(posedge S_AXI_ACLK)
		rst |=> !ready)
		else $error("ready high in the first cycle after reset");

	// Only a new seed wakes the engine up.
	a_done_holds: assert property (@(posedge S_AXI_ACLK) disable iff (rst)
		(state == csa_pkg::ENG_DONE) && !seed_valid |=> (state == csa_pkg::ENG_DONE))
		else $error("engine left ENG_DONE without a seed");

endmodule

bind csa_iterate csa_key_core_props u_csa_key_core_props (
	.S_AXI_ACLK (S_AXI_ACLK),
	.rst        (rst),
	.ready      (ready),
	.seed_valid (seed_valid),
	.state      (state)
);

//--- hdl/csa_key_core.sv
module csa_key_core (
	input  logic                          S_AXI_ACLK,
	input  logic                          rst,
	input  logic                          wen,
	input  logic [csa_pkg::ADDR_W-1:0]    waddr,
	input  logic [csa_pkg::DATA_W-1:0]    S_AXI_WDATA,
	input  logic                          ren,
	input  logic [csa_pkg::ADDR_W-1:0]    raddr,
	output logic [csa_pkg::DATA_W-1:0]    rdata,
	output logic [csa_pkg::RESULT_W-1:0]  byte_ram_out,
	output logic                          ready
);

	logic                      start;
	logic [csa_pkg::CNT_W-1:0] item_total;
	logic [csa_pkg::CNT_W-1:0] item_idx;
	logic [39:0]               item_bytes;
	logic                      seed_req;
	logic                      seed_valid;
	logic [csa_pkg::CW_W-1:0]  seed_cw;
	logic                      all_done;

	csa_ram u_csa_ram (
		.S_AXI_ACLK  (S_AXI_ACLK),
		.rst         (rst),
		.wen         (wen),
		.waddr       (waddr),
		.S_AXI_WDATA (S_AXI_WDATA),
		.ren         (ren),
		.raddr       (raddr),
		.rdata       (rdata),
		.item_idx    (item_idx),
		.item_bytes  (item_bytes),
		.start       (start),
		.item_total  (item_total)
	);

	csa_seed_unpack u_csa_seed_unpack (
		.S_AXI_ACLK (S_AXI_ACLK),
		.rst        (rst),
		.start      (start),
		.item_total (item_total),
		.seed_req   (seed_req),
		.item_idx   (item_idx),
		.item_bytes (item_bytes),
		.seed_valid (seed_valid),
		.seed_cw    (seed_cw),
		.all_done   (all_done)
	);

	csa_iterate u_csa_iterate (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.rst          (rst),
		.seed_valid   (seed_valid),
		.seed_cw      (seed_cw),
		.all_done     (all_done),
		.seed_req     (seed_req),
		.byte_ram_out (byte_ram_out),
		.ready        (ready)
	);

endmodule

//--- hdl/csa_iterate.sv
module csa_iterate (
	input  logic                          S_AXI_ACLK,
	input  logic                          rst,
	input  logic                          seed_valid,
	input  logic [csa_pkg::CW_W-1:0]      seed_cw,
	input  logic                          all_done,
	output logic                          seed_req,
	output logic [csa_pkg::RESULT_W-1:0]  byte_ram_out,
	output logic                          ready
);

	csa_pkg::eng_state_e       state;
	logic [csa_pkg::CNT_W-1:0] n;       // Iteration count.
	logic [csa_pkg::CW_W-1:0]  cw_q;
	logic [csa_pkg::CW_W-1:0]  cw;
	logic [csa_pkg::CW_W-1:0]  cb;
	logic [csa_pkg::CW_W-1:0]  cw_next;
	logic [csa_pkg::RESULT_W-1:0] result;
	logic [7:0]                n8;
	logic [7:0]                p0, p1, p2, p4, p5, p6;
	logic                      iter_en;
	logic                      last_iter;

	// Iteration 0 runs in the seed cycle.
	assign iter_en = seed_valid || (state == csa_pkg::ENG_RUN);
	assign last_iter = (n == csa_pkg::MAX_CAL_TIMES - 1);
	assign cw = seed_valid ? seed_cw : cw_q;

	stream_cypher u_stream_cypher (
		.sb (csa_pkg::SB_INIT),
		.cw (cw),
		.cb (cb)
	);

	assign n8 = {{(8 - csa_pkg::CNT_W){1'b0}}, n};

	assign p0 = (cb[7:0] ^ csa_pkg::KEY_MASK0) + n8;
	assign p1 = (cb[15:8] ^ csa_pkg::KEY_MASK1) + n8;
	assign p2 = (cb[23:16] ^ csa_pkg::KEY_MASK2) + n8;
	assign p4 = (cb[39:32] ^ csa_pkg::KEY_MASK4) + n8;
	assign p5 = (cb[47:40] ^ csa_pkg::KEY_MASK5) + n8;
	assign p6 = (cb[55:48] ^ csa_pkg::KEY_MASK5) + n8; // Same D7 mask as byte 5.

	assign cw_next = {p4 + p5 + p6, p6, p5, p4, p0 + p1 + p2, p2, p1, p0};

	assign result = cb[csa_pkg::RESULT_W-1:0] ^ {csa_pkg::KEY_MASK5, csa_pkg::KEY_MASK4,
		csa_pkg::KEY_MASK3, csa_pkg::KEY_MASK2, csa_pkg::KEY_MASK1, csa_pkg::KEY_MASK0};

	always_ff @(posedge S_AXI_ACLK) begin
		if (rst) begin
			state <= csa_pkg::ENG_IDLE;
			n <= '0;
			ready <= 1'b0;
			seed_req <= 1'b0;
		end else begin
			ready <= 1'b0;
			// Ask for the next item the cycle after ready.
			seed_req <= ready && (state == csa_pkg::ENG_SEED);
			if (iter_en) begin
				if (last_iter) begin
					n <= '0;
					ready <= 1'b1;
					state <= all_done ? csa_pkg::ENG_DONE : csa_pkg::ENG_SEED;
				end else begin
					n <= n + 1'b1;
					state <= csa_pkg::ENG_RUN;
				end
			end
		end
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (iter_en) begin
			if (last_iter)
				byte_ram_out <= result;
			else
				cw_q <= cw_next;
		end
	end

endmodule

//--- hdl/stream_cypher.sv
module stream_cypher (
	input  logic [csa_pkg::CW_W-1:0] sb,
	input  logic [csa_pkg::CW_W-1:0] cw,
	output logic [csa_pkg::CW_W-1:0] cb
);

	// Each byte mixes with its rotated upper neighbour.
	for (genvar i = 0; i < csa_pkg::CW_W / 8; i++) begin : g_byte
		logic [7:0] sb_b;
		logic [7:0] cw_b;
		logic [7:0] nb_b;
		logic [7:0] nb_rot;

		assign sb_b = sb[i*8 +: 8];
		assign cw_b = cw[i*8 +: 8];
		assign nb_b = cw[((i + 1) % (csa_pkg::CW_W / 8))*8 +: 8];
		assign nb_rot = {nb_b[6:0], nb_b[7]};

		assign cb[i*8 +: 8] = sb_b ^ cw_b ^ nb_rot;
	end

endmodule

//--- hdl/csa_seed_unpack.sv
module csa_seed_unpack (
	input  logic                      S_AXI_ACLK,
	input  logic                      rst,
	input  logic                      start,
	input  logic [csa_pkg::CNT_W-1:0] item_total,
	input  logic                      seed_req,
	output logic [csa_pkg::CNT_W-1:0] item_idx,
	input  logic [39:0]               item_bytes,
	output logic                      seed_valid,
	output logic [csa_pkg::CW_W-1:0]  seed_cw,
	output logic                      all_done
);

	logic [csa_pkg::CNT_W-1:0] cursor;
	logic [csa_pkg::CNT_W-1:0] total;
	logic                      rd_pend; // Store read in flight.
	logic                      last_item;
	logic [7:0]                b0, b1, b2, b3, b4;

	// First item is read on the start cycle itself.
	assign item_idx = start ? '0 : cursor;
	assign last_item = (cursor == total - 1'b1);

	assign b0 = item_bytes[7:0];
	assign b1 = item_bytes[15:8];
	assign b2 = item_bytes[23:16];
	assign b3 = item_bytes[31:24];
	assign b4 = item_bytes[39:32];

	always_ff @(posedge S_AXI_ACLK) begin
		if (rst) begin
			cursor <= '0;
			total <= '0;
			rd_pend <= 1'b0;
			seed_valid <= 1'b0;
			all_done <= 1'b0;
		end else begin
			seed_valid <= 1'b0;
			rd_pend <= 1'b0;
			if (start) begin
				cursor <= '0;
				total <= item_total;
				all_done <= (item_total == '0); // Nothing to hand over.
				rd_pend <= (item_total != '0);
			end else if (seed_req && !all_done) begin
				rd_pend <= 1'b1;
			end
			if (rd_pend) begin
				seed_valid <= 1'b1;
				if (last_item)
					all_done <= 1'b1;
				else
					cursor <= cursor + 1'b1;
			end
		end
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (rd_pend)
			seed_cw <= {b3 + b4, 8'h00, b4, b3, b0 + b1 + b2, b2, b1, b0};
	end

endmodule

//--- hdl/csa_ram.sv
module csa_ram (
	input  logic                       S_AXI_ACLK,
	input  logic                       rst,
	input  logic                       wen,
	input  logic [csa_pkg::ADDR_W-1:0] waddr,
	input  logic [csa_pkg::DATA_W-1:0] S_AXI_WDATA,
	input  logic                       ren,
	input  logic [csa_pkg::ADDR_W-1:0] raddr,
	output logic [csa_pkg::DATA_W-1:0] rdata,
	input  logic [csa_pkg::CNT_W-1:0]  item_idx,
	output logic [39:0]                item_bytes,
	output logic                       start,
	output logic [csa_pkg::CNT_W-1:0]  item_total
);

	logic [csa_pkg::DATA_W-1:0] byte_ram [csa_pkg::STORE_WORDS];
	logic [csa_pkg::CNT_W-1:0]  wr_cursor; // Words written so far.
	logic [csa_pkg::CNT_W+1:0]  words_x4;
	logic [6:0]                 item_base;
	logic                       append;

	assign append = wen && (waddr == csa_pkg::STEP_STUFFING_DATA) &&
		(wr_cursor < csa_pkg::STORE_WORDS);
	assign words_x4 = {wr_cursor, 2'b00};

	always_ff @(posedge S_AXI_ACLK) begin
		if (rst) begin
			wr_cursor <= '0;
			start <= 1'b0;
			item_total <= '0;
		end else begin
			start <= 1'b0;
			if (wen) begin
				case (csa_pkg::step_e'(waddr))
					csa_pkg::STEP_REQ_STUFF: begin
						wr_cursor <= '0;
					end
					csa_pkg::STEP_STUFFING_DATA: begin
						if (append)
							wr_cursor <= wr_cursor + 1'b1;
					end
					csa_pkg::STEP_FIN_STUFF: begin
						start <= 1'b1;
						item_total <= csa_pkg::CNT_W'(words_x4 / 5); // Whole items only.
					end
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (append)
			byte_ram[wr_cursor] <= S_AXI_WDATA;
	end

	// Host readback.
	always_ff @(posedge S_AXI_ACLK) begin
		if (ren) begin
			if (raddr < wr_cursor)
				rdata <= byte_ram[raddr];
			else
				rdata <= {csa_pkg::RD_ERR_TAG,
					{(csa_pkg::DATA_W - 16 - csa_pkg::ADDR_W){1'b0}}, raddr};
		end
	end

	assign item_base = ({2'b00, item_idx} << 2) + {2'b00, item_idx}; // Byte offset 5*idx.

	for (genvar k = 0; k < csa_pkg::ITEM_BYTES; k++) begin : g_item_byte
		logic [6:0] byte_addr;

		assign byte_addr = item_base + 7'(k);

		always_ff @(posedge S_AXI_ACLK) begin
			item_bytes[k*8 +: 8] <= byte_ram[byte_addr[6:2]][byte_addr[1:0]*8 +: 8];
		end
	end

endmodule

//--- hdl/csa_pkg.sv
package csa_pkg;

	// Host register interface.
	localparam int DATA_W = 32;
	localparam int ADDR_W = 4;

	// Key item store.
	localparam int ITEM_BYTES = 5;
	localparam int MAX_ITEMS = 16;
	localparam int STORE_WORDS = (MAX_ITEMS * ITEM_BYTES) / 4;

	// Iteration engine.
	localparam int MAX_CAL_TIMES = 10;
	localparam int CNT_W = 5;
	localparam int RESULT_W = 48;
	localparam int CW_W = 64;

	// Fixed cipher state.
	localparam logic [CW_W-1:0] SB_INIT = 64'hE613DB6DC11C4524;

	// Output byte masks, byte 0 first.
	localparam logic [7:0] KEY_MASK0 = 8'hB5;
	localparam logic [7:0] KEY_MASK1 = 8'h93;
	localparam logic [7:0] KEY_MASK2 = 8'h5E;
	localparam logic [7:0] KEY_MASK3 = 8'hD6;
	localparam logic [7:0] KEY_MASK4 = 8'hB0;
	localparam logic [7:0] KEY_MASK5 = 8'hD7;

	// Upper half of a readback for an unwritten address.
	localparam logic [15:0] RD_ERR_TAG = 16'hE000;

	// Write address opcodes.
	typedef enum logic [ADDR_W-1:0] {
		STEP_REQ_STUFF     = 4'd0,
		STEP_STUFFING_DATA = 4'd1,
		STEP_FIN_STUFF     = 4'd2
	} step_e;

	typedef enum logic [1:0] {
		ENG_IDLE,
		ENG_SEED,
		ENG_RUN,
		ENG_DONE
	} eng_state_e;

endpackage
